//--- riscv_ctrl_slave.f
hdl/axi_lite_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/axi_write_channel.sv
hdl/axi_read_channel.sv
hdl/ctrl_reg_file.sv
hdl/riscv_ctrl_slave.sv
testbench/riscv_ctrl_slave_asserts.sv
testbench/riscv_ctrl_slave_tb.sv

//--- Bender.yml
package:
  name: riscv_ctrl_slave

sources:
  # Packages first, then the RTL in dependency order
  - hdl/axi_lite_pkg.sv
  - hdl/core_ctrl_pkg.sv
  - hdl/axi_write_channel.sv
  - hdl/axi_read_channel.sv
  - hdl/ctrl_reg_file.sv
  - hdl/riscv_ctrl_slave.sv

  - target: test
    files:
      - testbench/riscv_ctrl_slave_asserts.sv
      - testbench/riscv_ctrl_slave_tb.sv

//--- testbench/riscv_ctrl_slave_tb.sv
`timescale 1ns/1ns

module riscv_ctrl_slave_tb;

    localparam int data_width  = 32;
    localparam int addr_width  = 5;
    localparam int strb_width  = data_width / axi_lite_pkg::strb_byte_width;
    localparam int clk_period  = 100;
    localparam int drive_delay = 10;
    // Roughly eight times the length of the tests
    localparam int max_cycles  = 2000;

    logic                  S_AXI_ACLK;
    logic                  S_AXI_ARESETN;
    logic [addr_width-1:0] S_AXI_AWADDR;
    logic                  S_AXI_AWVALID;
    logic                  S_AXI_AWREADY;
    logic [data_width-1:0] S_AXI_WDATA;
    logic [strb_width-1:0] S_AXI_WSTRB;
    logic                  S_AXI_WVALID;
    logic                  S_AXI_WREADY;
    logic [1:0]            S_AXI_BRESP;
    logic                  S_AXI_BVALID;
    logic                  S_AXI_BREADY;
    logic [addr_width-1:0] S_AXI_ARADDR;
    logic                  S_AXI_ARVALID;
    logic                  S_AXI_ARREADY;
    logic [data_width-1:0] S_AXI_RDATA;
    logic [1:0]            S_AXI_RRESP;
    logic                  S_AXI_RVALID;
    logic                  S_AXI_RREADY;
    logic                  core_rst;
    logic [data_width-1:0] base_addr;

    // Reference copy of the register file
    logic [data_width-1:0] model [core_ctrl_pkg::num_regs];
    int seed = 32'h368d_e48b;
    int cycle_count = 0;

    riscv_ctrl_slave #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) uut (.*);

    initial
    begin
        S_AXI_ACLK = 1'b0;
        forever #(clk_period / 2) S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // ----------------------------------------------------------------------
    // Run limits and failure exits
    // ----------------------------------------------------------------------

    always @(posedge S_AXI_ACLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
            $display("tests failed");
            $fatal(1, "stopped by timeout");
        end
    end

    // Stop at the first failed protocol assertion
    always @(posedge S_AXI_ACLK)
    begin
        if (uut.u_asserts.error_count != 0)
        begin
            $display("A protocol assertion on the DUT ports failed");
            $display("tests failed");
            $fatal(1, "stopped on protocol assertion");
        end
    end

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "value check failed");
    endtask

    // Strobed bytes take the new value and the rest keep the old
    function automatic logic [data_width-1:0] merge_bytes(input logic [data_width-1:0] old_v,
        input logic [data_width-1:0] new_v, input logic [strb_width-1:0] strb);
        logic [data_width-1:0] res;
        res = old_v;
        for (int b = 0; b < strb_width; b++)
        begin
            if (strb[b])
            begin
                res[b*8 +: 8] = new_v[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // ----------------------------------------------------------------------
    // Bus tasks entered and left a drive delay after an edge
    // ----------------------------------------------------------------------

    task automatic offer_write(input int idx, input logic [data_width-1:0] data,
        input logic [strb_width-1:0] strb);
        S_AXI_AWADDR  = addr_width'(idx << 2);
        S_AXI_WDATA   = data;
        S_AXI_WSTRB   = strb;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
    endtask

    // Address and data handshake only with the response left to the caller
    task automatic send_write(input int idx, input logic [data_width-1:0] data,
        input logic [strb_width-1:0] strb);
        offer_write(idx, data, strb);
        while (!S_AXI_AWREADY)
        begin
            @(posedge S_AXI_ACLK);
            #drive_delay;
        end
        // Transfer edge
        @(posedge S_AXI_ACLK);
        #drive_delay;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        model[idx] = merge_bytes(model[idx], data, strb);
    endtask

    task automatic take_write_resp();
        S_AXI_BREADY = 1'b1;
        while (!S_AXI_BVALID)
        begin
            @(posedge S_AXI_ACLK);
            #drive_delay;
        end
        assert (S_AXI_BRESP == axi_lite_pkg::resp_okay)
            else report_mismatch("write response is not OKAY");
        @(posedge S_AXI_ACLK);
        #drive_delay;
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic write_word(input int idx, input logic [data_width-1:0] data,
        input logic [strb_width-1:0] strb);
        send_write(idx, data, strb);
        take_write_resp();
    endtask

    task automatic send_read(input int idx);
        S_AXI_ARADDR  = addr_width'(idx << 2);
        S_AXI_ARVALID = 1'b1;
        while (!S_AXI_ARREADY)
        begin
            @(posedge S_AXI_ACLK);
            #drive_delay;
        end
        @(posedge S_AXI_ACLK);
        #drive_delay;
        S_AXI_ARVALID = 1'b0;
    endtask

    // Optional stall with RREADY low before the data is taken
    task automatic take_read_data(input int idx, input int stall);
        repeat (stall)
        begin
            @(posedge S_AXI_ACLK);
            #drive_delay;
        end
        while (!S_AXI_RVALID)
        begin
            @(posedge S_AXI_ACLK);
            #drive_delay;
        end
        assert (S_AXI_RDATA === model[idx])
            else report_mismatch($sformatf("register %0d read %h, expected %h",
                idx, S_AXI_RDATA, model[idx]));
        assert (S_AXI_RRESP == axi_lite_pkg::resp_okay)
            else report_mismatch("read response is not OKAY");
        S_AXI_RREADY = 1'b1;
        @(posedge S_AXI_ACLK);
        #drive_delay;
        S_AXI_RREADY = 1'b0;
    endtask

    task automatic read_and_check(input int idx);
        send_read(idx);
        take_read_data(idx, 0);
    endtask

    task automatic check_core_outputs();
        assert (core_rst === (model[0] != '0))
            else report_mismatch($sformatf("core_rst is %b with hold word %h", core_rst, model[0]));
        assert (base_addr === model[1])
            else report_mismatch($sformatf("base_addr %h, expected %h", base_addr, model[1]));
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial
    begin
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        for (int i = 0; i < core_ctrl_pkg::num_regs; i++)
        begin
            model[i] = '0;
        end
        // Hold word comes up set
        model[0] = 1;
        repeat (4) @(posedge S_AXI_ACLK);
        #drive_delay;
        S_AXI_ARESETN = 1'b1;

        // Reset state
        assert (!S_AXI_AWREADY && !S_AXI_WREADY && !S_AXI_ARREADY)
            else report_mismatch("a ready is high after reset");
        assert (!S_AXI_BVALID && !S_AXI_RVALID)
            else report_mismatch("a valid is high after reset");
        check_core_outputs();
        for (int i = 0; i < core_ctrl_pkg::num_regs; i++)
        begin
            read_and_check(i);
        end

        // Full-word writes
        for (int i = 0; i < core_ctrl_pkg::num_regs; i++)
        begin
            data = $random(seed);
            write_word(i, data, '1);
            read_and_check(i);
        end
        check_core_outputs();

        // Strobed writes in two passes over the map
        repeat (2)
        begin
            for (int i = 0; i < core_ctrl_pkg::num_regs; i++)
            begin
                data = $random(seed);
                strb = $random(seed);
                write_word(i, data, strb);
                read_and_check(i);
                check_core_outputs();
            end
        end

        // Core release and re-hold
        write_word(0, '0, '1);
        assert (!core_rst) else report_mismatch("core_rst still high after hold cleared");
        check_core_outputs();
        write_word(0, 32'h0000_5a00, 4'b0010);
        assert (core_rst) else report_mismatch("core_rst low with a hold bit set");
        data = $random(seed);
        write_word(1, data, '1);
        check_core_outputs();

        // Write response held back so the second write must wait
        data = $random(seed);
        send_write(3, data, '1);
        offer_write(4, ~data, '1);
        repeat (4)
        begin
            @(posedge S_AXI_ACLK);
            #drive_delay;
            assert (!S_AXI_AWREADY)
                else report_mismatch("second write taken before the response");
        end
        take_write_resp();
        send_write(4, ~data, '1);
        take_write_resp();
        read_and_check(3);
        read_and_check(4);

        // Read data stalled so the next read must wait
        send_read(5);
        S_AXI_ARADDR  = addr_width'(6 << 2);
        S_AXI_ARVALID = 1'b1;
        repeat (4)
        begin
            @(posedge S_AXI_ACLK);
            #drive_delay;
            assert (!S_AXI_ARREADY)
                else report_mismatch("second read taken while data pending");
        end
        take_read_data(5, 0);
        send_read(6);
        take_read_data(6, 5);

        if (uut.u_asserts.error_count == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            $display("tests failed");
            $fatal(1, "protocol assertions failed during the run");
        end
    end

endmodule

//--- testbench/riscv_ctrl_slave_asserts.sv
`timescale 1ns/1ns

module riscv_ctrl_slave_asserts #(
    parameter int data_width = 32
) (
    input logic                  S_AXI_ACLK,
    input logic                  S_AXI_ARESETN,
    input logic                  S_AXI_AWREADY,
    input logic                  S_AXI_WREADY,
    input logic [1:0]            S_AXI_BRESP,
    input logic                  S_AXI_BVALID,
    input logic                  S_AXI_BREADY,
    input logic                  S_AXI_ARREADY,
    input logic [data_width-1:0] S_AXI_RDATA,
    input logic [1:0]            S_AXI_RRESP,
    input logic                  S_AXI_RVALID,
    input logic                  S_AXI_RREADY
);

    // Count of failed protocol assertions
    int error_count = 0;

    // ----------------------------------------------------------------------
    // Write side
    // ----------------------------------------------------------------------

    // Address and data are always taken together
    a_ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_AWREADY == S_AXI_WREADY)
    else
    begin
        $error("AWREADY and WREADY differ");
        error_count++;
    end

    // Single-cycle ready pulse
    a_awready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_AWREADY |=> !S_AXI_AWREADY)
    else
    begin
        $error("AWREADY held longer than one cycle");
        error_count++;
    end

    // Response waits for the master
    a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
    else
    begin
        $error("BVALID dropped before BREADY");
        error_count++;
    end

    a_bresp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID |-> S_AXI_BRESP == axi_lite_pkg::resp_okay)
    else
    begin
        $error("BRESP not OKAY");
        error_count++;
    end

    // No new write while a response is unclaimed
    a_no_write_in_resp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID |-> !S_AXI_AWREADY)
    else
    begin
        $error("AWREADY raised while BVALID pending");
        error_count++;
    end

    // ----------------------------------------------------------------------
    // Read side
    // ----------------------------------------------------------------------

    a_arready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_ARREADY |=> !S_AXI_ARREADY)
    else
    begin
        $error("ARREADY held longer than one cycle");
        error_count++;
    end

    // Data frozen under back-pressure
    a_rdata_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
    else
    begin
        $error("RVALID or RDATA changed before RREADY");
        error_count++;
    end

    a_rresp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID |-> S_AXI_RRESP == axi_lite_pkg::resp_okay)
    else
    begin
        $error("RRESP not OKAY");
        error_count++;
    end

endmodule

bind riscv_ctrl_slave riscv_ctrl_slave_asserts #(
    .data_width (data_width)
) u_asserts (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_ARREADY (S_AXI_ARREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .S_AXI_RRESP   (S_AXI_RRESP),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY)
);

//--- hdl/riscv_ctrl_slave.sv
`timescale 1ns/1ns

module riscv_ctrl_slave #(
    parameter int data_width = 32,
    parameter int addr_width = 5
) (
    input  logic                                                S_AXI_ACLK,
    input  logic                                                S_AXI_ARESETN,
    // Write address channel
    input  logic [addr_width-1:0]                               S_AXI_AWADDR,
    input  logic                                                S_AXI_AWVALID,
    output logic                                                S_AXI_AWREADY,
    // Write data channel
    input  logic [data_width-1:0]                               S_AXI_WDATA,
    input  logic [data_width/axi_lite_pkg::strb_byte_width-1:0] S_AXI_WSTRB,
    input  logic                                                S_AXI_WVALID,
    output logic                                                S_AXI_WREADY,
    // Write response channel
    output logic [1:0]                                          S_AXI_BRESP,
    output logic                                                S_AXI_BVALID,
    input  logic                                                S_AXI_BREADY,
    // Read address channel
    input  logic [addr_width-1:0]                               S_AXI_ARADDR,
    input  logic                                                S_AXI_ARVALID,
    output logic                                                S_AXI_ARREADY,
    // Read data channel
    output logic [data_width-1:0]                               S_AXI_RDATA,
    output logic [1:0]                                          S_AXI_RRESP,
    output logic                                                S_AXI_RVALID,
    input  logic                                                S_AXI_RREADY,
    // Core controls
    output logic                                                core_rst,
    output logic [data_width-1:0]                               base_addr
);

    // Write command path
    logic                                                wr_en;
    logic [core_ctrl_pkg::reg_index_bits-1:0]            wr_index;
    logic [data_width-1:0]                               wr_data;
    logic [data_width/axi_lite_pkg::strb_byte_width-1:0] wr_strb;
    // Read lookup path
    logic [core_ctrl_pkg::reg_index_bits-1:0]            rd_index;
    logic [data_width-1:0]                               rd_data;

    axi_write_channel #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) u_write (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb)
    );

    axi_read_channel #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) u_read (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .rd_index      (rd_index),
        .rd_data       (rd_data)
    );

    ctrl_reg_file #(
        .data_width (data_width)
    ) u_regs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .rd_index      (rd_index),
        .rd_data       (rd_data),
        .core_rst      (core_rst),
        .base_addr     (base_addr)
    );

endmodule

//--- hdl/ctrl_reg_file.sv
`timescale 1ns/1ns

module ctrl_reg_file #(
    parameter int data_width = 32
) (
    input  logic                                                S_AXI_ACLK,
    input  logic                                                S_AXI_ARESETN,
    // Write command from the write channel
    input  logic                                                wr_en,
    input  logic [core_ctrl_pkg::reg_index_bits-1:0]            wr_index,
    input  logic [data_width-1:0]                               wr_data,
    input  logic [data_width/axi_lite_pkg::strb_byte_width-1:0] wr_strb,
    // Read lookup from the read channel
    input  logic [core_ctrl_pkg::reg_index_bits-1:0]            rd_index,
    output logic [data_width-1:0]                               rd_data,
    // Core-facing controls
    output logic                                                core_rst,
    output logic [data_width-1:0]                               base_addr
);

    localparam int byte_bits  = axi_lite_pkg::strb_byte_width;
    localparam int strb_width = data_width / byte_bits;

    logic [data_width-1:0] regs [core_ctrl_pkg::num_regs];

    // ------------------------------------------------------------------
    // Register array with byte-strobed writes
    // ------------------------------------------------------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            for (int i = 0; i < core_ctrl_pkg::num_regs; i++)
            begin
                regs[i] <= '0;
            end
            // Hold word overrides the clear so the core starts frozen
            regs[core_ctrl_pkg::reg_hold] <=
                data_width'(core_ctrl_pkg::hold_reset_value);
        end
        else if (wr_en)
        begin
            // Unstrobed bytes keep their old value
            for (int b = 0; b < strb_width; b++)
            begin
                if (wr_strb[b])
                begin
                    regs[wr_index][b*byte_bits +: byte_bits] <=
                        wr_data[b*byte_bits +: byte_bits];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------

    // Index covers all eight words so none is out of range
    always_comb
    begin
        rd_data = regs[rd_index];
    end

    // ------------------------------------------------------------------
    // Core-facing outputs
    // ------------------------------------------------------------------

    // Any set bit of the hold word holds the core in reset
    assign core_rst  = |regs[core_ctrl_pkg::reg_hold];
    assign base_addr = regs[core_ctrl_pkg::reg_base_addr];

endmodule

//--- hdl/axi_read_channel.sv
`timescale 1ns/1ns

module axi_read_channel #(
    parameter int data_width = 32,
    parameter int addr_width = 5
) (
    input  logic                                     S_AXI_ACLK,
    input  logic                                     S_AXI_ARESETN,
    // Read address channel
    input  logic [addr_width-1:0]                    S_AXI_ARADDR,
    input  logic                                     S_AXI_ARVALID,
    output logic                                     S_AXI_ARREADY,
    // Read data channel
    output logic [data_width-1:0]                    S_AXI_RDATA,
    output logic [1:0]                               S_AXI_RRESP,
    output logic                                     S_AXI_RVALID,
    input  logic                                     S_AXI_RREADY,
    // Register file lookup
    output logic [core_ctrl_pkg::reg_index_bits-1:0] rd_index,
    input  logic [data_width-1:0]                    rd_data
);

    // Word select starts at bit 2 for 32-bit data and at bit 3 for 64-bit data
    localparam int addr_lsb = (data_width / 32) + 1;

    logic                  ar_ready;
    logic                  rvalid;
    logic                  rd_en;
    logic [addr_width-1:0] araddr_q;
    logic [data_width-1:0] rdata_q;

    // ------------------------------------------------------------------
    // Read address acceptance
    // ------------------------------------------------------------------

    // Held off while data is still waiting for RREADY
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            ar_ready <= 1'b0;
        end
        else
        begin
            ar_ready <= !ar_ready && S_AXI_ARVALID && !rvalid;
        end
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!ar_ready && S_AXI_ARVALID && !rvalid)
        begin
            araddr_q <= S_AXI_ARADDR;
        end
    end

    assign S_AXI_ARREADY = ar_ready;
    assign rd_index      = araddr_q[addr_lsb +: core_ctrl_pkg::reg_index_bits];

    // ------------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------------

    // Address handshake in this cycle
    assign rd_en = ar_ready && S_AXI_ARVALID;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            rvalid <= 1'b0;
        end
        else if (rd_en)
        begin
            rvalid <= 1'b1;
        end
        else if (S_AXI_RREADY)
        begin
            rvalid <= 1'b0;
        end
    end

    // Captured once per read and frozen until the next one
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_en)
        begin
            rdata_q <= rd_data;
        end
    end

    assign S_AXI_RVALID = rvalid;
    assign S_AXI_RDATA  = rdata_q;
    assign S_AXI_RRESP  = axi_lite_pkg::resp_okay;

endmodule

//--- hdl/axi_write_channel.sv
`timescale 1ns/1ns

module axi_write_channel #(
    parameter int data_width = 32,
    parameter int addr_width = 5
) (
    input  logic                                                  S_AXI_ACLK,
    input  logic                                                  S_AXI_ARESETN,
    // Write address channel
    input  logic [addr_width-1:0]                                 S_AXI_AWADDR,
    input  logic                                                  S_AXI_AWVALID,
    output logic                                                  S_AXI_AWREADY,
    // Write data channel
    input  logic [data_width-1:0]                                 S_AXI_WDATA,
    input  logic [data_width/axi_lite_pkg::strb_byte_width-1:0]   S_AXI_WSTRB,
    input  logic                                                  S_AXI_WVALID,
    output logic                                                  S_AXI_WREADY,
    // Write response channel
    output logic [1:0]                                            S_AXI_BRESP,
    output logic                                                  S_AXI_BVALID,
    input  logic                                                  S_AXI_BREADY,
    // Write command to the register file
    output logic                                                  wr_en,
    output logic [core_ctrl_pkg::reg_index_bits-1:0]              wr_index,
    output logic [data_width-1:0]                                 wr_data,
    output logic [data_width/axi_lite_pkg::strb_byte_width-1:0]   wr_strb
);

    // Word select starts at bit 2 for 32-bit data and at bit 3 for 64-bit data
    localparam int addr_lsb = (data_width / 32) + 1;

    // Shared ready for address and data taken together
    logic                  wr_ready;
    // Low while a write is in flight or its response is unclaimed
    logic                  aw_en;
    logic                  bvalid;
    logic [addr_width-1:0] awaddr_q;
    logic                  accept;

    // ------------------------------------------------------------------
    // Address and data acceptance
    // ------------------------------------------------------------------

    // Both valids present and nothing outstanding
    assign accept = !wr_ready && S_AXI_AWVALID && S_AXI_WVALID && aw_en;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            wr_ready <= 1'b0;
            aw_en    <= 1'b1;
        end
        else if (accept)
        begin
            // Single-cycle ready pulse on both channels
            wr_ready <= 1'b1;
            aw_en    <= 1'b0;
        end
        else
        begin
            wr_ready <= 1'b0;
            // Reopen once the master has taken the response
            if (bvalid && S_AXI_BREADY)
            begin
                aw_en <= 1'b1;
            end
        end
    end

    // Address held for the ready cycle
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (accept)
        begin
            awaddr_q <= S_AXI_AWADDR;
        end
    end

    assign S_AXI_AWREADY = wr_ready;
    assign S_AXI_WREADY  = wr_ready;

    // ------------------------------------------------------------------
    // Write command live during the ready cycle
    // ------------------------------------------------------------------

    assign wr_en    = wr_ready && S_AXI_AWVALID && S_AXI_WVALID;
    assign wr_index = awaddr_q[addr_lsb +: core_ctrl_pkg::reg_index_bits];
    assign wr_data  = S_AXI_WDATA;
    assign wr_strb  = S_AXI_WSTRB;

    // ------------------------------------------------------------------
    // Write response
    // ------------------------------------------------------------------

    // Rises with the register update and falls on BREADY
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            bvalid <= 1'b0;
        end
        else if (wr_en)
        begin
            bvalid <= 1'b1;
        end
        else if (S_AXI_BREADY)
        begin
            bvalid <= 1'b0;
        end
    end

    assign S_AXI_BVALID = bvalid;
    // Every write succeeds
    assign S_AXI_BRESP  = axi_lite_pkg::resp_okay;

endmodule

//--- hdl/core_ctrl_pkg.sv
// ----------------------------------------------------------------------
// Register map of the core control block
// ----------------------------------------------------------------------

package core_ctrl_pkg;

    // Eight words of control space
    localparam int num_regs = 8;

    // Index width into the register array
    // Must cover num_regs
    localparam int reg_index_bits = 3;

    // Core hold word
    // Any set bit keeps the core in reset
    localparam int reg_hold = 0;

    // DRAM base address seen by the core
    localparam int reg_base_addr = 1;

    // Registers 2 to 7 are free scratch words

    // Hold word comes out of reset set
    // Core starts frozen until software clears it
    localparam int hold_reset_value = 1;

endpackage

//--- hdl/axi_lite_pkg.sv
// ----------------------------------------------------------------------
// AXI4-Lite protocol constants
// ----------------------------------------------------------------------

package axi_lite_pkg;

    // Response codes on BRESP and RRESP
    // Only OKAY is ever returned by this slave
    localparam logic [1:0] resp_okay = 2'b00;

    // One write strobe bit per data byte
    // Strobe width of a port is data_width / strb_byte_width
    localparam int strb_byte_width = 8;

endpackage
